/* tb.f */
hw/vio_switch_pkg.sv
hw/stream_reg_slice.sv
hw/ingress_port.sv
hw/egress_port.sv
hw/vio_switch.sv
sim/vio_switch_assertions.sv
sim/tb_vio_switch.sv

/* Makefile */
# Verilator build and run for the vIO stream switch testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_vio_switch
FILELIST  := tb.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := TEST OK
# Keep running after an assertion error so the testbench can report it
RUNFLAGS  := +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/tb_vio_switch.sv */
// Testbench for the vIO stream switch: random packets on all sinks,
// random source back-pressure and final beat and drop counts

`timescale 1ns/1ns

module tb_vio_switch;
  import vio_switch_pkg::*;

  localparam int PKTS_PER_PORT = 30;
  localparam int SEND_TIMEOUT  = 20000;
  localparam int DRAIN_TIMEOUT = 2000;

  logic                       aclk;
  logic                       rst_n      = 1'b0;
  stream_beat_t [N_PORTS-1:0] sink_beat  = '0;
  port_mask_t                 sink_valid = '0;
  port_mask_t                 sink_ready;
  stream_beat_t [N_PORTS-1:0] src_beat;
  port_mask_t                 src_valid;
  port_mask_t                 src_ready  = '0;
  logic [DEST_BITS-1:0]       route_in   = '0;
  logic [DEST_BITS-1:0]       route_out;
  port_mask_t                 decode_err;

  int seed = 21;
  bit go   = 1'b0;

  // Per sink packet state
  int pkts_left  [N_PORTS] = '{default: PKTS_PER_PORT};
  int beats_left [N_PORTS] = '{default: 0};
  int pkt_dest   [N_PORTS] = '{default: 0};
  int seq_next   [N_PORTS][N_PORTS] = '{default: '{default: 0}};

  // Scoreboard counters, drops are kept per sink port
  int tx_count   [N_PORTS] = '{default: 0};
  int rx_count   [N_PORTS] = '{default: 0};
  int bad_tx     [N_PORTS] = '{default: 0};
  int drop_count [N_PORTS] = '{default: 0};

  vio_switch DUT (
    .aclk       (aclk),
    .rst_n      (rst_n),
    .sink_beat  (sink_beat),
    .sink_valid (sink_valid),
    .sink_ready (sink_ready),
    .src_beat   (src_beat),
    .src_valid  (src_valid),
    .src_ready  (src_ready),
    .route_in   (route_in),
    .route_out  (route_out),
    .decode_err (decode_err)
  );

  bind vio_switch vio_switch_checks u_checks (
    .aclk       (aclk),
    .rst_n      (rst_n),
    .src_beat   (src_beat),
    .src_valid  (src_valid),
    .src_ready  (src_ready),
    .route_out  (route_out),
    .decode_err (decode_err)
  );

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  task automatic abort_run(input string reason);
    $display("error: %s", reason);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  function automatic bit sinks_done();
    bit done;
    done = (sink_valid == '0);
    for (int i = 0; i < N_PORTS; i++) begin
      if (pkts_left[i] != 0 || beats_left[i] != 0) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  function automatic int beats_sent();
    int sum;
    sum = 0;
    for (int o = 0; o < N_PORTS; o++) begin
      sum += tx_count[o] + bad_tx[o];
    end
    return sum;
  endfunction

  function automatic int beats_seen();
    int sum;
    sum = 0;
    for (int o = 0; o < N_PORTS; o++) begin
      sum += rx_count[o] + drop_count[o];
    end
    return sum;
  endfunction

  always @(posedge aclk) begin : drive_ports
    logic [31:0]  r;
    logic [31:0]  rdy;
    stream_beat_t b;
    int           d;
    int           seq;
    // Each source is ready about three cycles in four
    rdy = $random(seed) | $random(seed);
    src_ready <= rdy[N_PORTS-1:0];
    if (go) begin
      for (int i = 0; i < N_PORTS; i++) begin
        if (!sink_valid[i] || sink_ready[i]) begin
          r = $random(seed);
          if (beats_left[i] == 0 && pkts_left[i] > 0 && r[0]) begin
            beats_left[i] = int'(r[2:1]) + 1;
            pkts_left[i]--;
            // Roughly one packet in sixteen goes nowhere
            if (r[6:3] == 4'd0) begin
              pkt_dest[i] = N_PORTS + int'(r[15:7]);
            end else begin
              pkt_dest[i] = int'(r[15:8]) % N_PORTS;
            end
          end
          if (beats_left[i] > 0 && r[17:16] != 2'd0) begin
            d   = pkt_dest[i];
            seq = 0;
            if (d < N_PORTS) begin
              seq = seq_next[i][d];
              seq_next[i][d]++;
              tx_count[d]++;
            end else begin
              bad_tx[i]++;
            end
            b.tdata = {d[7:0], i[7:0], 16'h0000, seq[31:0]};
            b.tkeep = '1;
            b.tlast = (beats_left[i] == 1);
            b.tid   = PID_BITS'(i);
            b.tdest = DEST_BITS'(d);
            if (i == PORT_VFIU) begin
              // Own tdest is junk here, route_in steers the beat
              b.tdest = ~DEST_BITS'(d);
              route_in <= DEST_BITS'(d);
            end
            beats_left[i]--;
            sink_beat[i]  <= b;
            sink_valid[i] <= 1'b1;
          end else begin
            sink_valid[i] <= 1'b0;
          end
        end
      end
    end
  end

  always @(posedge aclk) begin : count_outputs
    if (rst_n) begin
      for (int o = 0; o < N_PORTS; o++) begin
        if (src_valid[o] && src_ready[o]) rx_count[o]++;
        if (decode_err[o]) drop_count[o]++;
      end
    end
    if (DUT.u_checks.check_failed) begin
      abort_run("a concurrent assertion on the switch failed");
    end
  end

  initial begin : main_flow
    int cycles;
    bit bad;
    repeat (2) @(posedge aclk);
    rst_n <= 1'b1;
    repeat (4) @(posedge aclk);
    go <= 1'b1;

    cycles = 0;
    while (!sinks_done()) begin
      if (cycles > SEND_TIMEOUT) begin
        abort_run("sinks did not finish sending their packets in time");
      end else begin
        @(negedge aclk);
        cycles++;
      end
    end

    cycles = 0;
    while (beats_seen() < beats_sent()) begin
      if (cycles > DRAIN_TIMEOUT) begin
        abort_run("switch did not deliver or drop all beats in time");
      end else begin
        @(negedge aclk);
        cycles++;
      end
    end
    // Extra cycles expose any beat that arrives twice
    repeat (20) @(negedge aclk);

    bad = 1'b0;
    for (int o = 0; o < N_PORTS; o++) begin
      if (!bad && rx_count[o] != tx_count[o]) begin
        $display("mismatch at %0t: rx_count[%0d] expected %0d got %0d",
                 $time, o, tx_count[o], rx_count[o]);
        bad = 1'b1;
      end
      if (!bad && drop_count[o] != bad_tx[o]) begin
        $display("mismatch at %0t: drop_count[%0d] expected %0d got %0d",
                 $time, o, bad_tx[o], drop_count[o]);
        bad = 1'b1;
      end
    end
    if (DUT.u_checks.check_failed) begin
      abort_run("a concurrent assertion on the switch failed");
    end else if (bad) begin
      abort_run("received and dropped beats do not match the beats sent");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

/* sim/vio_switch_assertions.sv */
// Concurrent checks on the switch sources: routing, packet atomicity,
// per-source ordering, back-pressure hold and quiet outputs after reset

`timescale 1ns/1ns

module vio_switch_checks
  import vio_switch_pkg::*;
(
  input logic                       aclk,
  input logic                       rst_n,
  input stream_beat_t [N_PORTS-1:0] src_beat,
  input port_mask_t                 src_valid,
  input port_mask_t                 src_ready,
  input logic [DEST_BITS-1:0]       route_out,
  input port_mask_t                 decode_err
);

  // Raised by any failing assertion, watched by the testbench top
  bit check_failed = 1'b0;

  logic [N_PORTS-1:0]  in_pkt;
  logic [PID_BITS-1:0] pkt_tid [N_PORTS];
  // Next expected sequence number per output and source
  logic [31:0]         next_seq [N_PORTS][2**PORT_BITS];

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      in_pkt <= '0;
      for (int o = 0; o < N_PORTS; o++) begin
        for (int s = 0; s < 2**PORT_BITS; s++) begin
          next_seq[o][s] <= '0;
        end
      end
    end else begin
      for (int o = 0; o < N_PORTS; o++) begin
        if (src_valid[o] && src_ready[o]) begin
          in_pkt[o]  <= !src_beat[o].tlast;
          pkt_tid[o] <= src_beat[o].tid;
          next_seq[o][src_beat[o].tid[PORT_BITS-1:0]] <= src_beat[o].tdata[31:0] + 32'd1;
        end
      end
    end
  end

  // Nothing leaves the switch in the first cycles after reset
  a_reset_quiet: assert property (@(posedge aclk)
    rst_n && (!$past(rst_n) || !$past(rst_n, 2)) |-> src_valid == '0 && decode_err == '0)
  else begin
    $error("source valid or decode error active right after reset");
    check_failed = 1'b1;
  end

  // A beat on the vFIU source is addressed to the vFIU port
  a_route_out: assert property (@(posedge aclk) disable iff (!rst_n)
    src_valid[PORT_VFIU] |-> route_out == DEST_BITS'(PORT_VFIU))
  else begin
    $error("route_out differs from the vFIU port index");
    check_failed = 1'b1;
  end

  for (genvar o = 0; o < N_PORTS; o++) begin : g_src
    a_dest: assert property (@(posedge aclk) disable iff (!rst_n)
      src_valid[o] |-> src_beat[o].tdest == DEST_BITS'(o) && src_beat[o].tdata[63:56] == 8'(o))
    else begin
      $error("beat on source %0d addressed to another port", o);
      check_failed = 1'b1;
    end

    a_packet: assert property (@(posedge aclk) disable iff (!rst_n)
      src_valid[o] && in_pkt[o] |-> src_beat[o].tid == pkt_tid[o])
    else begin
      $error("packet on source %0d interleaved with another source", o);
      check_failed = 1'b1;
    end

    a_order: assert property (@(posedge aclk) disable iff (!rst_n)
      src_valid[o] |-> src_beat[o].tid < PID_BITS'(N_PORTS) &&
        src_beat[o].tdata[31:0] == next_seq[o][src_beat[o].tid[PORT_BITS-1:0]])
    else begin
      $error("beat on source %0d lost or out of order", o);
      check_failed = 1'b1;
    end

    a_hold: assert property (@(posedge aclk) disable iff (!rst_n)
      src_valid[o] && !src_ready[o] |=> src_valid[o] && $stable(src_beat[o]))
    else begin
      $error("source %0d changed while stalled", o);
      check_failed = 1'b1;
    end
  end

endmodule

/* hw/vio_switch.sv */
// vIO stream switch top: ten ingress and ten egress ports,
// request/take matrix transposes and vFIU route substitution

`timescale 1ns/1ns

module vio_switch
  import vio_switch_pkg::*;
(
  input  logic                       aclk,
  input  logic                       rst_n,

  input  stream_beat_t [N_PORTS-1:0] sink_beat,
  input  port_mask_t                 sink_valid,
  output port_mask_t                 sink_ready,

  output stream_beat_t [N_PORTS-1:0] src_beat,
  output port_mask_t                 src_valid,
  input  port_mask_t                 src_ready,

  input  logic [DEST_BITS-1:0]       route_in,
  output logic [DEST_BITS-1:0]       route_out,
  output port_mask_t                 decode_err
);

  stream_beat_t [N_PORTS-1:0] fabric_in;
  stream_beat_t [N_PORTS-1:0] heads;

  // Indexed [input][output]
  port_mask_t [N_PORTS-1:0] req_by_in;
  port_mask_t [N_PORTS-1:0] take_by_in;
  // Indexed [output][input]
  port_mask_t [N_PORTS-1:0] req_by_out;
  port_mask_t [N_PORTS-1:0] take_by_out;

  // vFIU sink is steered by route_in, not by its own tdest
  always_comb begin
    fabric_in                  = sink_beat;
    fabric_in[PORT_VFIU].tdest = route_in;
  end

  assign route_out = src_beat[PORT_VFIU].tdest;

  for (genvar i = 0; i < N_PORTS; i++) begin : g_xpose
    for (genvar o = 0; o < N_PORTS; o++) begin : g_cell
      assign req_by_out[o][i] = req_by_in[i][o];
      assign take_by_in[i][o] = take_by_out[o][i];
    end
  end

  for (genvar i = 0; i < N_PORTS; i++) begin : g_ingress
    ingress_port u_ingress (
      .aclk       (aclk),
      .rst_n      (rst_n),
      .sink_beat  (fabric_in[i]),
      .sink_valid (sink_valid[i]),
      .sink_ready (sink_ready[i]),
      .take       (take_by_in[i]),
      .head       (heads[i]),
      .req        (req_by_in[i]),
      .decode_err (decode_err[i])
    );
  end

  for (genvar o = 0; o < N_PORTS; o++) begin : g_egress
    egress_port u_egress (
      .aclk      (aclk),
      .rst_n     (rst_n),
      .req       (req_by_out[o]),
      .heads     (heads),
      .take      (take_by_out[o]),
      .src_beat  (src_beat[o]),
      .src_valid (src_valid[o]),
      .src_ready (src_ready[o])
    );
  end

endmodule

/* hw/egress_port.sv */
// Switch egress: round-robin packet arbiter, beat multiplexer
// and output slice for one source

`timescale 1ns/1ns

module egress_port
  import vio_switch_pkg::*;
(
  input  logic                       aclk,
  input  logic                       rst_n,
  input  port_mask_t                 req,
  input  stream_beat_t [N_PORTS-1:0] heads,
  output port_mask_t                 take,
  output stream_beat_t               src_beat,
  output logic                       src_valid,
  input  logic                       src_ready
);

  // Last granted input, also the owner while a packet is locked
  logic [PORT_BITS-1:0] grant_ptr;
  logic                 locked;

  logic [PORT_BITS-1:0] pick;
  logic                 pick_valid;
  logic [PORT_BITS-1:0] sel;
  logic                 sel_valid;
  stream_beat_t         sel_beat;
  logic                 slice_ready;
  logic                 accept;

  // Nearest requester after the last grant, wrapping around
  always_comb begin : rr_pick
    int idx;
    pick       = grant_ptr;
    pick_valid = 1'b0;
    for (int k = 1; k <= N_PORTS; k++) begin
      idx = (int'(grant_ptr) + k) % N_PORTS;
      if (!pick_valid && req[idx]) begin
        pick       = PORT_BITS'(idx);
        pick_valid = 1'b1;
      end
    end
  end

  // Inside a packet only the owner may send
  assign sel       = locked ? grant_ptr : pick;
  assign sel_valid = locked ? req[grant_ptr] : pick_valid;
  assign sel_beat  = heads[sel];

  assign accept = sel_valid && slice_ready;
  assign take   = accept ? (port_mask_t'(1) << sel) : '0;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      // Start the search at input 0
      grant_ptr <= PORT_BITS'(N_PORTS - 1);
      locked    <= 1'b0;
    end else if (accept) begin
      grant_ptr <= sel;
      // Lock holds until the tlast beat has been taken
      locked    <= !sel_beat.tlast;
    end
  end

  stream_reg_slice #(
    .payload_t (stream_beat_t)
  ) u_out_slice (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .in_data   (sel_beat),
    .in_valid  (sel_valid),
    .in_ready  (slice_ready),
    .out_data  (src_beat),
    .out_valid (src_valid),
    .out_ready (src_ready)
  );

endmodule

/* hw/ingress_port.sv */
// Switch ingress: input slice, destination decode and drop of
// beats whose destination is not a port

`timescale 1ns/1ns

module ingress_port
  import vio_switch_pkg::*;
(
  input  logic         aclk,
  input  logic         rst_n,
  input  stream_beat_t sink_beat,
  input  logic         sink_valid,
  output logic         sink_ready,
  input  port_mask_t   take,
  output stream_beat_t head,
  output port_mask_t   req,
  output logic         decode_err
);

  routed_beat_t in_routed;
  routed_beat_t held;
  logic         held_valid;
  logic         in_range;
  logic         held_bad;
  logic         pop;

  // Decode on entry so the fabric sees a ready-made index
  assign in_range       = sink_beat.tdest < DEST_BITS'(N_PORTS);
  assign in_routed.beat = sink_beat;
  assign in_routed.port = in_range ? sink_beat.tdest[PORT_BITS-1:0] : '1;

  stream_reg_slice #(
    .payload_t (routed_beat_t)
  ) u_in_slice (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .in_data   (in_routed),
    .in_valid  (sink_valid),
    .in_ready  (sink_ready),
    .out_data  (held),
    .out_valid (held_valid),
    .out_ready (pop)
  );

  // All-ones port marks a beat nobody can take
  assign held_bad = held.port >= PORT_BITS'(N_PORTS);

  assign head = held.beat;

  // One-hot request towards the addressed output
  assign req = (held_valid && !held_bad) ? (port_mask_t'(1) << held.port) : '0;

  // A bad beat pops itself in the first cycle it is held
  assign pop        = (|take) || held_bad;
  assign decode_err = held_valid && held_bad;

endmodule

/* hw/stream_reg_slice.sv */
// Two-entry valid/ready register slice with a type-parameterized payload

`timescale 1ns/1ns

module stream_reg_slice #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     aclk,
  input  logic     rst_n,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  payload_t skid_data;
  logic     skid_valid;
  logic     out_load;

  // Ready only depends on the skid flop
  assign in_ready = !skid_valid;

  // Output register takes a new beat whenever it is empty or draining
  assign out_load = out_ready || !out_valid;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_load) begin
      // Skid entry drains first, else pass the incoming beat
      out_valid  <= skid_valid || in_valid;
      skid_valid <= 1'b0;
    end else if (in_valid && in_ready) begin
      // Output stalled, park the beat
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (out_load) begin
      out_data <= skid_valid ? skid_data : in_data;
    end
    if (!out_load && in_ready) begin
      skid_data <= in_data;
    end
  end

endmodule

/* hw/vio_switch_pkg.sv */
// Shared widths, port indices and stream beat types for the vIO stream switch

package vio_switch_pkg;

  // Stream payload widths
  localparam int DATA_BITS = 64;
  localparam int KEEP_BITS = DATA_BITS / 8;
  localparam int PID_BITS  = 6;
  localparam int DEST_BITS = 14;

  // One vFIU region, then the fixed service ports
  localparam int N_VFIU    = 1;
  localparam int N_PORTS   = N_VFIU + 9;
  localparam int PORT_BITS = 4;

  // Port indices, same order on the sink and source side
  localparam int PORT_VFIU          = 0;
  localparam int PORT_HOST_TX       = N_VFIU;
  localparam int PORT_HOST_RX       = N_VFIU + 1;
  localparam int PORT_RDMA_RX       = N_VFIU + 2;
  localparam int PORT_RDMA_TX_REQ   = N_VFIU + 3;
  localparam int PORT_RDMA_TX_RSP   = N_VFIU + 4;
  localparam int PORT_TCP           = N_VFIU + 5;
  localparam int PORT_BYPASS_RX     = N_VFIU + 6;
  localparam int PORT_BYPASS_TX_REQ = N_VFIU + 7;
  localparam int PORT_BYPASS_TX_RSP = N_VFIU + 8;

  // One beat of a valid/ready stream
  typedef struct packed {
    logic [DATA_BITS-1:0] tdata;
    logic [KEEP_BITS-1:0] tkeep;
    logic                 tlast;
    logic [PID_BITS-1:0]  tid;
    logic [DEST_BITS-1:0] tdest;
  } stream_beat_t;

  // Beat plus the output index decoded at ingress
  // Out-of-range destinations carry an all-ones port
  typedef struct packed {
    stream_beat_t         beat;
    logic [PORT_BITS-1:0] port;
  } routed_beat_t;

  // One bit per switch port
  typedef logic [N_PORTS-1:0] port_mask_t;

endpackage
